//--- vlog.f
+incdir+test
hw/mic_pkg.sv
hw/tdm_pkg.sv
hw/i2s_rx.sv
hw/tdm_sequencer.sv
hw/channel_gain.sv
hw/channel_mixer.sv
hw/mic_array_top.sv
test/tb_mic_array.sv

//--- test/tb_i2s_drive.svh
// ======================================================================
// stimulus helpers, included inside tb_mic_array
// ======================================================================

logic [31:0] lcg_state = 32'd89;                // seed

// 32-bit LCG, upper bits are the useful ones
function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
endfunction

// one bclk period: fall, 4 cycles low, rise, 4 cycles high
task automatic drive_bit(input logic lr, input logic [num_mics-1:0] bits);
        @(posedge CLOCK_50);
        bclk   <= 1'b0;
        lrclk  <= lr;                           // word clock moves on the fall
        mic_sd <= bits;
        repeat (3) @(posedge CLOCK_50);
        @(posedge CLOCK_50);
        bclk <= 1'b1;                           // receiver samples here
        repeat (3) @(posedge CLOCK_50);
endtask

// 32 bclk per frame, data one bit behind lrclk
// period 16 carries left LSB with lrclk already high,
// period 32 carries right LSB with lrclk back low
task automatic send_frame();
        logic [num_mics-1:0] bits;
        logic                lr;
        for (int p = 1; p <= 32; p++)
        begin
                lr = (p >= 16 && p < 32);
                for (int k = 0; k < num_mics; k++)
                begin
                        if (p <= 16)
                                bits[k] = l_smp[k][16-p];       // MSB first
                        else
                                bits[k] = r_smp[k][32-p];
                end
                drive_bit(lr, bits);
        end
endtask

// expected mix: sum of sample * gain * volume over one side
function automatic logic signed [63:0] expect_mix(input bit side);
        logic signed [63:0] acc;
        logic signed [63:0] s;
        logic signed [63:0] v;
        acc = '0;
        for (int k = 0; k < num_mics; k++)
        begin
                s   = side ? r_smp[k] : l_smp[k];       // sign extended
                v   = vol_cfg[2*k + side];              // zero extended
                acc = acc + s * v * mic_gain;
        end
        return acc;
endfunction

//--- test/tb_mic_array.sv
`timescale 1ns/10ps

module tb_mic_array
        import mic_pkg::*;
();

        logic                CLOCK_50 = 1'b0;
        logic                rst;
        logic                bclk;
        logic                lrclk;
        logic [num_mics-1:0] mic_sd;
        vol_set_t            vol;
        mix_t                left;
        mix_t                right;
        logic                mix_valid;

        sample_t  l_smp [num_mics];     // words the driver sends
        sample_t  r_smp [num_mics];
        vol_set_t vol_cfg;              // volumes for the next frame
        int       checks = 0;
        int       errors = 0;

        `include "tb_i2s_drive.svh"

        always
        begin
                #10 CLOCK_50 = ~CLOCK_50;       // 50 MHz
        end

        mic_array_top mic_array_top_i (
                .CLOCK_50  (CLOCK_50),
                .rst       (rst),
                .bclk      (bclk),
                .lrclk     (lrclk),
                .mic_sd    (mic_sd),
                .vol       (vol),
                .left      (left),
                .right     (right),
                .mix_valid (mix_valid)
        );

        // ======================================================================
        // checking
        // ======================================================================
        task automatic compare(input string name, input logic signed [63:0] exp,
                               input logic signed [63:0] act);
                checks++;
                if (exp !== act)
                begin
                        $display("ERROR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
                        errors++;
                end
        endtask

        task automatic report(input string name, input int err_before);
                $display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
        endtask

        // send one frame, wait for the mix, compare both sides
        task automatic run_frame(input string name, input logic signed [63:0] exp_l,
                                 input logic signed [63:0] exp_r);
                int wait_cnt;
                @(posedge CLOCK_50);
                vol <= vol_cfg;                 // only between frames
                send_frame();
                wait_cnt = 0;
                @(negedge CLOCK_50);
                while (!mix_valid && wait_cnt < 400)
                begin
                        @(negedge CLOCK_50);
                        wait_cnt++;
                end
                if (!mix_valid)
                begin
                        $display("timeout waiting for mix_valid in %s", name);
                        errors++;
                end
                else
                begin
                        compare({name, " left"}, exp_l, left);
                        compare({name, " right"}, exp_r, right);
                end
        endtask

        // ======================================================================
        // directed tests
        // ======================================================================
        task automatic test_reset();
                int e0;
                e0 = errors;
                repeat (7)
                begin
                        @(posedge CLOCK_50);
                        @(negedge CLOCK_50);    // outputs settled
                        compare("mix_valid", 0, mix_valid);
                        compare("left", 0, left);
                        compare("right", 0, right);
                end
                @(posedge CLOCK_50);
                rst <= 1'b0;                    // eighth edge still sees reset
                repeat (4)
                begin
                        @(negedge CLOCK_50);
                        compare("mix_valid", 0, mix_valid);
                        compare("left", 0, left);
                        compare("right", 0, right);
                end
                report("reset", e0);
        endtask

        task automatic test_single_mic();
                int e0;
                e0 = errors;
                for (int k = 0; k < num_mics; k++)
                begin
                        l_smp[k] = '0;
                        r_smp[k] = '0;
                end
                l_smp[0] = 16'sd100;
                r_smp[0] = -16'sd50;
                for (int c = 0; c < num_chans; c++)
                        vol_cfg[c] = 8'd1;
                run_frame("single_mic", 1000, -500);    // 100*10, -50*10
                report("single_mic", e0);
        endtask

        task automatic test_volume();
                int e0;
                e0 = errors;
                l_smp = '{16'sd1200, -16'sd3400, 16'sd560, -16'sd7};
                r_smp = '{-16'sd900, 16'sd2500, 16'sd31, 16'sd12000};
                for (int c = 0; c < num_chans; c++)
                        vol_cfg[c] = vol_t'(c + 1);     // 1..8
                run_frame("volume", expect_mix(0), expect_mix(1));
                report("volume", e0);
        endtask

        task automatic test_random();
                int e0;
                e0 = errors;
                for (int f = 0; f < 6; f++)
                begin
                        for (int k = 0; k < num_mics; k++)
                        begin
                                l_smp[k] = sample_t'(lcg_next() >> 16);
                                r_smp[k] = sample_t'(lcg_next() >> 16);
                        end
                        for (int c = 0; c < num_chans; c++)
                                vol_cfg[c] = vol_t'(lcg_next() >> 24);
                        run_frame($sformatf("random frame %0d", f), expect_mix(0), expect_mix(1));
                end
                report("random", e0);
        endtask

        task automatic test_extremes();
                int e0;
                e0 = errors;
                for (int c = 0; c < num_chans; c++)
                        vol_cfg[c] = 8'd255;
                for (int k = 0; k < num_mics; k++)
                begin
                        l_smp[k] = -16'sd32768;         // full-scale negative
                        r_smp[k] = -16'sd32768;
                end
                run_frame("extreme low", expect_mix(0), expect_mix(1));
                for (int k = 0; k < num_mics; k++)
                begin
                        l_smp[k] = 16'sd32767;
                        r_smp[k] = 16'sd32767;
                end
                run_frame("extreme high", expect_mix(0), expect_mix(1));
                report("extremes", e0);
        endtask

        // ======================================================================
        // sequence
        // ======================================================================
        initial
        begin
                rst    <= 1'b1;
                bclk   <= 1'b0;
                lrclk  <= 1'b0;                 // idle on the left half
                mic_sd <= '0;
                vol    <= '0;
                vol_cfg = '0;
                test_reset();
                test_single_mic();
                test_volume();
                test_random();
                test_extremes();
                $display("checks %0d, errors %0d", checks, errors);
                if (errors == 0)
                        $display("TEST RESULT: PASS");
                else
                        $display("TEST RESULT: FAIL");
                $finish;
        end

endmodule

//--- hw/mic_array_top.sv
`timescale 1ns/10ps

module mic_array_top
        import mic_pkg::*, tdm_pkg::*;
(
        input  logic                CLOCK_50,
        input  logic                rst,
        input  logic                bclk,
        input  logic                lrclk,
        input  logic [num_mics-1:0] mic_sd,
        input  vol_set_t            vol,
        output mix_t                left,
        output mix_t                right,
        output logic                mix_valid
);

        mic_pair_t [num_mics-1:0] pairs;        // one per microphone
        logic                     frame_strobe; // from receiver 0
        tdm_beat_t                seq_beat;     // gain applied, before volume
        tdm_beat_t                gain_beat;    // after volume

        // ======================================================================
        // I2S receivers, shared bclk/lrclk
        // ======================================================================
        for (genvar i = 0; i < num_mics; i++)
        begin : g_rx
                if (i == 0)
                begin : g_lead
                        // all lines framed alike, one strobe is enough
                        i2s_rx rx_i (
                                .CLOCK_50   (CLOCK_50),
                                .rst        (rst),
                                .bclk       (bclk),
                                .lrclk      (lrclk),
                                .sd         (mic_sd[i]),
                                .pair       (pairs[i]),
                                .pair_valid (frame_strobe)
                        );
                end
                else
                begin : g_follow
                        i2s_rx rx_i (
                                .CLOCK_50   (CLOCK_50),
                                .rst        (rst),
                                .bclk       (bclk),
                                .lrclk      (lrclk),
                                .sd         (mic_sd[i]),
                                .pair       (pairs[i]),
                                .pair_valid ()
                        );
                end
        end

        // ======================================================================
        // stream path
        // ======================================================================
        tdm_sequencer seq_i (
                .CLOCK_50     (CLOCK_50),
                .rst          (rst),
                .frame_strobe (frame_strobe),
                .pairs        (pairs),
                .beat         (seq_beat)
        );

        channel_gain gain_i (
                .CLOCK_50 (CLOCK_50),
                .rst      (rst),
                .vol      (vol),
                .beat_in  (seq_beat),
                .beat_out (gain_beat)
        );

        channel_mixer mixer_i (
                .CLOCK_50  (CLOCK_50),
                .rst       (rst),
                .beat      (gain_beat),
                .left      (left),
                .right     (right),
                .mix_valid (mix_valid)
        );

endmodule

//--- hw/channel_mixer.sv
`timescale 1ns/10ps

module channel_mixer
        import mic_pkg::*, tdm_pkg::*;
(
        input  logic      CLOCK_50,
        input  logic      rst,
        input  tdm_beat_t beat,
        output mix_t      left,
        output mix_t      right,
        output logic      mix_valid
);

        mix_t hold [num_chans];         // latest value per channel
        mix_t cur  [num_chans];         // hold with incoming beat bypassed
        mix_t sum_even;                 // mic left channels
        mix_t sum_odd;                  // mic right channels
        logic last_beat;

        assign last_beat = beat.valid & beat.eop;

        // ======================================================================
        // group sums
        // ======================================================================
        always_comb
        begin
                sum_even = '0;
                sum_odd  = '0;
                for (int c = 0; c < num_chans; c++)
                begin
                        cur[c] = (beat.valid && beat.chan == chan_t'(c)) ? beat.data : hold[c];
                        if (c % 2 == 0)
                                sum_even = sum_even + cur[c];
                        else
                                sum_odd = sum_odd + cur[c];
                end
        end

        always_ff @(posedge CLOCK_50)
        begin
                if (rst)
                begin
                        hold      <= '{default: '0};
                        left      <= '0;
                        right     <= '0;
                        mix_valid <= 1'b0;
                end
                else
                begin
                        if (beat.valid)
                                hold[beat.chan] <= beat.data;
                        mix_valid <= last_beat;         // one cycle after eop
                        if (last_beat)
                        begin
                                left  <= sum_even;
                                right <= sum_odd;
                        end
                end
        end

        // eop closes a full burst, so it must be the last channel
        a_eop_is_last : assert property (
                @(posedge CLOCK_50) disable iff (rst)
                last_beat |-> (beat.chan == last_chan));

endmodule

//--- hw/channel_gain.sv
`timescale 1ns/10ps

module channel_gain
        import mic_pkg::*, tdm_pkg::*;
(
        input  logic      CLOCK_50,
        input  logic      rst,
        input  vol_set_t  vol,
        input  tdm_beat_t beat_in,
        output tdm_beat_t beat_out
);

        // ======================================================================
        // stage 1: pick the volume for this beat's channel
        // ======================================================================
        tdm_beat_t s1_beat;
        vol_t      s1_vol;

        always_ff @(posedge CLOCK_50)
        begin
                if (rst)
                        s1_beat <= '0;
                else
                        s1_beat <= beat_in;
        end

        always_ff @(posedge CLOCK_50)
        begin
                s1_vol <= vol[beat_in.chan];
        end

        // ======================================================================
        // stage 2: multiply, tags ride along
        // ======================================================================
        mix_t product;

        // zero-extended volume so the multiply stays signed
        assign product = mix_t'(s1_beat.data * $signed({1'b0, s1_vol}));

        always_ff @(posedge CLOCK_50)
        begin
                if (rst)
                        beat_out <= '0;
                else
                begin
                        beat_out      <= s1_beat;
                        beat_out.data <= product;
                end
        end

        // burst framing from the sequencer
        a_sop_is_chan0 : assert property (
                @(posedge CLOCK_50) disable iff (rst)
                (beat_in.valid && beat_in.sop) |-> (beat_in.chan == '0));

endmodule

//--- hw/tdm_sequencer.sv
`timescale 1ns/10ps

module tdm_sequencer
        import mic_pkg::*, tdm_pkg::*;
(
        input  logic                     CLOCK_50,
        input  logic                     rst,
        input  logic                     frame_strobe,
        input  mic_pair_t [num_mics-1:0] pairs,
        output tdm_beat_t                beat
);

        scaled_t scaled [num_chans];    // gain applied, live
        scaled_t hold   [num_chans];    // frame snapshot for beats 1..7
        chan_t   cnt;                   // next channel to send
        logic    busy;                  // burst running
        logic    start;

        assign start = frame_strobe & ~busy;    // strobe mid-burst is dropped

        // ======================================================================
        // front-end gain, channel 2k left / 2k+1 right
        // ======================================================================
        always_comb
        begin
                for (int k = 0; k < num_mics; k++)
                begin
                        scaled[2*k]   = scaled_t'(pairs[k].left * mic_gain);
                        scaled[2*k+1] = scaled_t'(pairs[k].right * mic_gain);
                end
        end

        always_ff @(posedge CLOCK_50)
        begin
                if (start)
                        hold <= scaled;
        end

        // ======================================================================
        // burst walker
        // ======================================================================
        always_ff @(posedge CLOCK_50)
        begin
                if (rst)
                begin
                        busy <= 1'b0;
                        cnt  <= '0;
                        beat <= '0;
                end
                else if (start)
                begin
                        // beat 0 straight from the inputs, one cycle after strobe
                        beat.valid <= 1'b1;
                        beat.sop   <= 1'b1;
                        beat.eop   <= 1'b0;
                        beat.chan  <= '0;
                        beat.data  <= mix_t'(scaled[0]);   // sign extend
                        cnt        <= chan_t'(1);
                        busy       <= 1'b1;
                end
                else if (busy)
                begin
                        beat.valid <= 1'b1;
                        beat.sop   <= 1'b0;
                        beat.eop   <= (cnt == last_chan);
                        beat.chan  <= cnt;
                        beat.data  <= mix_t'(hold[cnt]);
                        cnt        <= cnt + 1'b1;          // wraps to 0 after 7
                        busy       <= (cnt != last_chan);
                end
                else
                        beat <= '0;                        // idle
        end

        // no back-pressure, frames must not overlap a burst
        a_no_strobe_in_burst : assert property (
                @(posedge CLOCK_50) disable iff (rst) frame_strobe |-> !busy);

endmodule

//--- hw/i2s_rx.sv
`timescale 1ns/10ps

module i2s_rx
        import mic_pkg::*;
(
        input  logic      CLOCK_50,
        input  logic      rst,
        input  logic      bclk,
        input  logic      lrclk,
        input  logic      sd,
        output mic_pair_t pair,
        output logic      pair_valid
);

        // ======================================================================
        // input synchronizers
        // ======================================================================
        logic [2:0] bclk_sync;          // [1] synced level, [2] one cycle older
        logic [2:0] lrclk_sync;
        logic [1:0] sd_sync;            // [1] lines up with bclk_sync[1]

        always_ff @(posedge CLOCK_50)
        begin
                if (rst)
                begin
                        bclk_sync  <= '0;
                        lrclk_sync <= '0;
                        sd_sync    <= '0;
                end
                else
                begin
                        bclk_sync  <= {bclk_sync[1:0], bclk};
                        lrclk_sync <= {lrclk_sync[1:0], lrclk};
                        sd_sync    <= {sd_sync[0], sd};
                end
        end

        logic bclk_rise;
        logic lr_edge;

        assign bclk_rise = bclk_sync[1] & ~bclk_sync[2];
        assign lr_edge   = lrclk_sync[1] ^ lrclk_sync[2];   // either direction

        // ======================================================================
        // word capture
        // ======================================================================
        // the first rise after a word clock change still belongs to the old
        // word (one bit delay), so with 16 bclk per half the LSB lands there
        logic                 skip;         // next rise is the delayed slot
        logic                 old_right;    // side of the word just closed
        logic [bit_cnt_w-1:0] taken;        // bits of the current word
        sample_t              left_sr;
        sample_t              right_sr;
        logic                 shift_en;
        logic                 shift_right;
        logic                 word_done;    // right word complete

        assign shift_en    = bclk_rise && (taken < sample_w);  // extra bits dropped
        assign shift_right = skip ? old_right : lrclk_sync[1];

        always_ff @(posedge CLOCK_50)
        begin
                if (rst)
                begin
                        skip      <= 1'b0;
                        old_right <= 1'b0;
                        taken     <= '0;
                        left_sr   <= '0;
                        right_sr  <= '0;
                        word_done <= 1'b0;
                end
                else
                begin
                        word_done <= bclk_rise & skip & old_right;
                        if (lr_edge)
                        begin
                                skip      <= 1'b1;
                                old_right <= lrclk_sync[2];  // level before the change
                        end
                        else if (bclk_rise)
                        begin
                                if (shift_en && shift_right)
                                        right_sr <= {right_sr[sample_w-2:0], sd_sync[1]};
                                else if (shift_en)
                                        left_sr <= {left_sr[sample_w-2:0], sd_sync[1]};

                                if (skip)
                                begin
                                        skip  <= 1'b0;
                                        taken <= '0;            // new word starts counting
                                end
                                else if (shift_en)
                                        taken <= taken + 1'b1;
                        end
                end
        end

        // pair register, held until the next frame
        always_ff @(posedge CLOCK_50)
        begin
                if (rst)
                begin
                        pair       <= '0;
                        pair_valid <= 1'b0;
                end
                else
                begin
                        pair_valid <= word_done;
                        if (word_done)
                        begin
                                pair.left  <= left_sr;
                                pair.right <= right_sr;
                        end
                end
        end

        // one frame per strobe, never back to back
        a_pair_valid_pulse : assert property (
                @(posedge CLOCK_50) disable iff (rst) pair_valid |=> !pair_valid);

endmodule

//--- hw/tdm_pkg.sv
package tdm_pkg;

        import mic_pkg::*;

        // ======================================================================
        // tdm stream definitions
        // ======================================================================
        localparam int chan_w = $clog2(num_chans);      // 3 bits for 8 channels

        typedef logic [chan_w-1:0] chan_t;

        // last channel of a burst, carries eop
        localparam chan_t last_chan = chan_t'(num_chans - 1);

        // one beat of the burst
        // data is full mix width so the same beat
        // serves before and after the volume stage
        typedef struct packed {
                logic  valid;   // beat present this cycle
                logic  sop;     // channel 0
                logic  eop;     // channel 7
                chan_t chan;    // 2k = mic k left, 2k+1 = mic k right
                mix_t  data;    // signed sample
        } tdm_beat_t;

endpackage

//--- hw/mic_pkg.sv
package mic_pkg;

        // ======================================================================
        // array geometry
        // ======================================================================
        localparam int num_mics  = 4;                   // I2S data lines
        localparam int num_chans = 2 * num_mics;        // left + right per mic

        // ======================================================================
        // sample path widths
        // ======================================================================
        localparam int sample_w  = 16;                  // bits taken per I2S word
        localparam int mic_gain  = 10;                  // fixed front-end multiplier
        localparam int scaled_w  = 20;                  // 32767 * 10 still fits signed
        localparam int vol_w     = 8;
        localparam int mix_w     = 32;                  // four full-scale products, no wrap
        localparam int bit_cnt_w = $clog2(sample_w + 1); // counts 0..16

        typedef logic signed [sample_w-1:0] sample_t;

        // one microphone, both word clock halves
        typedef struct packed {
                sample_t left;   // lrclk low
                sample_t right;  // lrclk high
        } mic_pair_t;

        typedef logic signed [scaled_w-1:0] scaled_t;

        typedef logic [vol_w-1:0] vol_t;                // unsigned level, 0 mutes
        typedef vol_t [num_chans-1:0] vol_set_t;        // indexed by stream channel

        typedef logic signed [mix_w-1:0] mix_t;

endpackage
